// ==== rtl/spi_pkg.sv ====
package spi_pkg;

    // APB data word
    typedef logic [31:0] word_t;

    // Register offset from the low address bits
    typedef logic [4:0] reg_addr_t;

    // SPI frame, unused upper bits held at zero
    typedef logic [15:0] frame_t;

    // Shift engine states
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a buffered word
        LEAD,   // sclk at idle level, ends on the leading edge
        TRAIL,  // sclk at active level, ends on the trailing edge
        DONE    // Frame complete, rx_valid pulse
    } engine_state_t;

    // Register map
    localparam reg_addr_t DR_OFFS  = 5'h00;
    localparam reg_addr_t CR_OFFS  = 5'h04;
    localparam reg_addr_t SR_OFFS  = 5'h08;
    localparam reg_addr_t BRR_OFFS = 5'h0C;
    localparam reg_addr_t IER_OFFS = 5'h10;

    // CR fields
    localparam int CR_ENABLE    = 0;
    localparam int CR_MASTER    = 1;  // Read back only
    localparam int CR_CPHA      = 2;
    localparam int CR_CPOL      = 3;
    localparam int CR_MSB_FIRST = 4;
    localparam int CR_LEN_LSB   = 8;
    localparam int CR_LEN_MSB   = 11; // Zero selects 16 bits

    // SR flags
    localparam int SR_TBE  = 0;
    localparam int SR_RBF  = 1;
    localparam int SR_BUSY = 2;
    localparam int SR_OVR  = 3;

endpackage

// ==== rtl/spi_xfer_if.sv ====
interface spi_xfer_if #(
    parameter int BAUD_WIDTH = 16
) ();
    import spi_pkg::*;

    // Configuration from CR and BRR
    logic                  enable;
    logic                  cpol;
    logic                  cpha;
    logic                  msb_first;
    logic [3:0]            frame_len;
    logic [BAUD_WIDTH-1:0] baud;

    // Transmit buffer handoff
    frame_t                tx_data;
    logic                  tx_valid;
    logic                  tx_ready;

    // Received frame, one-cycle pulse
    frame_t                rx_data;
    logic                  rx_valid;

    logic                  busy;

    modport regs (
        output enable, cpol, cpha, msb_first, frame_len, baud,
        output tx_data, tx_valid,
        input  tx_ready, rx_data, rx_valid, busy
    );

    modport engine (
        input  enable, cpol, cpha, msb_first, frame_len, baud,
        input  tx_data, tx_valid,
        output tx_ready, rx_data, rx_valid, busy
    );

endinterface

// ==== rtl/spi_regs.sv ====
module spi_regs #(
    parameter int BAUD_WIDTH = 16
) (
    input  logic               seq,
    input  logic               reset,

    input  spi_pkg::reg_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  spi_pkg::word_t     pwdata,
    output spi_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr,

    output logic               irq,

    spi_xfer_if.regs           xfer
);
    import spi_pkg::*;

    // CR fields
    logic                  enable;
    logic                  master;
    logic                  cpha;
    logic                  cpol;
    logic                  msb_first;
    logic [3:0]            frame_len;

    logic [BAUD_WIDTH-1:0] brr;
    logic [3:0]            ier;      // Same bit layout as SR

    frame_t                tx_buf;
    frame_t                rx_buf;
    logic                  tx_full;  // TBE is the inverse
    logic                  rbf;
    logic                  ovr;

    logic                  access;
    logic                  hit_dr;
    logic                  hit_cr;
    logic                  hit_sr;
    logic                  hit_brr;
    logic                  hit_ier;
    logic                  err;
    logic                  wr_ok;
    logic                  rd_ok;
    logic                  dr_read;
    logic                  ovr_clr;
    word_t                 cr_word;
    word_t                 sr_word;
    logic [3:0]            irq_src;

    assign access  = psel & penable;
    assign hit_dr  = (paddr == DR_OFFS);
    assign hit_cr  = (paddr == CR_OFFS);
    assign hit_sr  = (paddr == SR_OFFS);
    assign hit_brr = (paddr == BRR_OFFS);
    assign hit_ier = (paddr == IER_OFFS);

    // Error response conditions
    always_comb begin
        err = 1'b0;
        if (!(hit_dr | hit_cr | hit_sr | hit_brr | hit_ier)) begin
            err = 1'b1;                             // Unmapped offset
        end else if (hit_dr && !enable) begin
            err = 1'b1;
        end else if (hit_dr && pwrite && tx_full) begin
            err = 1'b1;                             // Buffer still waiting
        end
    end

    assign pready  = 1'b1;                          // No wait states
    assign pslverr = access & err;
    assign wr_ok   = access & pwrite & ~err;
    assign rd_ok   = access & ~pwrite & ~err;
    assign dr_read = rd_ok & hit_dr;
    assign ovr_clr = wr_ok & hit_sr & pwdata[SR_OVR];

    always_comb begin
        cr_word                          = '0;
        cr_word[CR_ENABLE]               = enable;
        cr_word[CR_MASTER]               = master;
        cr_word[CR_CPHA]                 = cpha;
        cr_word[CR_CPOL]                 = cpol;
        cr_word[CR_MSB_FIRST]            = msb_first;
        cr_word[CR_LEN_MSB:CR_LEN_LSB]   = frame_len;

        sr_word                          = '0;
        sr_word[SR_TBE]                  = ~tx_full;
        sr_word[SR_RBF]                  = rbf;
        sr_word[SR_BUSY]                 = xfer.busy;
        sr_word[SR_OVR]                  = ovr;
    end

    // Read mux
    always_comb begin
        case (paddr)
            DR_OFFS:  prdata = word_t'(rx_buf);
            CR_OFFS:  prdata = cr_word;
            SR_OFFS:  prdata = sr_word;
            BRR_OFFS: prdata = word_t'(brr);
            IER_OFFS: prdata = word_t'(ier);
            default:  prdata = '0;
        endcase
    end

    // Configuration registers
    always_ff @(posedge seq) begin
        if (reset) begin
            enable    <= 1'b0;
            master    <= 1'b0;
            cpha      <= 1'b0;
            cpol      <= 1'b0;
            msb_first <= 1'b0;
            frame_len <= '0;
            brr       <= '0;
            ier       <= '0;
        end else if (wr_ok) begin
            if (hit_cr) begin
                enable    <= pwdata[CR_ENABLE];
                master    <= pwdata[CR_MASTER];
                cpha      <= pwdata[CR_CPHA];
                cpol      <= pwdata[CR_CPOL];
                msb_first <= pwdata[CR_MSB_FIRST];
                frame_len <= pwdata[CR_LEN_MSB:CR_LEN_LSB];
            end
            if (hit_brr) brr <= pwdata[BAUD_WIDTH-1:0];
            if (hit_ier) ier <= pwdata[3:0];
        end
    end

    // Status flags
    always_ff @(posedge seq) begin
        if (reset) begin
            tx_full <= 1'b0;
            rbf     <= 1'b0;
            ovr     <= 1'b0;
        end else begin
            if (wr_ok && hit_dr) begin
                tx_full <= 1'b1;
            end else if (xfer.tx_valid && xfer.tx_ready) begin
                tx_full <= 1'b0;                    // Engine took the word
            end

            // A new frame wins over a DR read in the same cycle
            if (xfer.rx_valid) begin
                rbf <= 1'b1;
            end else if (dr_read) begin
                rbf <= 1'b0;
            end

            if (ovr_clr) ovr <= 1'b0;
            if (xfer.rx_valid && rbf && !dr_read) ovr <= 1'b1;
        end
    end

    // Data buffers
    always_ff @(posedge seq) begin
        if (wr_ok && hit_dr) tx_buf <= pwdata[15:0];
        if (xfer.rx_valid) rx_buf <= xfer.rx_data;  // Overwrites on overrun
    end

    always_comb begin
        irq_src          = '0;
        irq_src[SR_TBE]  = ~tx_full;
        irq_src[SR_RBF]  = rbf;
        irq_src[SR_OVR]  = ovr;
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= |(irq_src & ier);
        end
    end

    assign xfer.enable    = enable;
    assign xfer.cpol      = cpol;
    assign xfer.cpha      = cpha;
    assign xfer.msb_first = msb_first;
    assign xfer.frame_len = frame_len;
    assign xfer.baud      = brr;
    assign xfer.tx_data   = tx_buf;
    assign xfer.tx_valid  = tx_full;

endmodule

// ==== rtl/spi_engine.sv ====
module spi_engine #(
    parameter int BAUD_WIDTH = 16
) (
    input  logic        seq,
    input  logic        reset,

    output logic        sclk,
    output logic        mosi,
    input  logic        miso,
    output logic        ss_n,

    spi_xfer_if.engine  xfer
);
    import spi_pkg::*;

    engine_state_t         state;
    logic [BAUD_WIDTH-1:0] baud_cnt;
    logic [BAUD_WIDTH-1:0] half_m1;    // Half period minus one
    logic [4:0]            bit_cnt;    // Bits left in the frame
    logic [4:0]            len_eff;

    // Frame settings held for the whole frame
    logic                  cpha_q;
    logic                  cpol_q;
    logic                  msb_q;
    logic [4:0]            len_q;

    frame_t                aligned;
    frame_t                aligned_next;
    frame_t                shift_tx;
    frame_t                shift_tx_next;
    frame_t                shift_rx;
    logic                  load_bit;
    logic                  next_bit;

    logic                  sclk_q;
    logic                  mosi_q;
    logic                  ss_q;

    logic                  take;
    logic                  half_end;
    logic                  lead_edge;
    logic                  trail_edge;
    logic                  drive;
    logic                  sample;

    assign len_eff = (xfer.frame_len == 4'd0) ? 5'd16 : {1'b0, xfer.frame_len};
    assign half_m1 = (xfer.baud == '0) ? '0 : xfer.baud - 1'b1;

    // MSB first puts the frame's top bit at bit 15
    assign aligned      = xfer.msb_first ? (xfer.tx_data << (5'd16 - len_eff)) : xfer.tx_data;
    assign aligned_next = xfer.msb_first ? (aligned << 1) : (aligned >> 1);
    assign load_bit     = xfer.msb_first ? aligned[15] : aligned[0];

    assign next_bit      = msb_q ? shift_tx[15] : shift_tx[0];
    assign shift_tx_next = msb_q ? (shift_tx << 1) : (shift_tx >> 1);

    assign take       = xfer.tx_valid & xfer.tx_ready;
    assign half_end   = (baud_cnt == '0);
    assign lead_edge  = (state == LEAD) & half_end;
    assign trail_edge = (state == TRAIL) & half_end;

    // cpha 0 samples on the leading edge and changes data on the trailing one
    assign sample = cpha_q ? trail_edge : lead_edge;
    assign drive  = cpha_q ? lead_edge : (trail_edge && bit_cnt != 5'd1);

    always_ff @(posedge seq) begin
        if (reset) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            sclk_q   <= 1'b0;
            mosi_q   <= 1'b0;
            ss_q     <= 1'b1;
        end else if (state != IDLE && !xfer.enable) begin
            state  <= IDLE;                         // Abort
            sclk_q <= xfer.cpol;
            ss_q   <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    sclk_q <= xfer.cpol;            // Idle level tracks CR
                    if (take) begin
                        state    <= LEAD;
                        ss_q     <= 1'b0;
                        baud_cnt <= half_m1;
                        bit_cnt  <= len_eff;
                        if (!xfer.cpha) mosi_q <= load_bit;
                    end
                end
                LEAD: begin
                    if (half_end) begin
                        state    <= TRAIL;
                        sclk_q   <= ~cpol_q;
                        baud_cnt <= half_m1;
                        if (drive) mosi_q <= next_bit;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                TRAIL: begin
                    if (half_end) begin
                        sclk_q   <= cpol_q;
                        baud_cnt <= half_m1;
                        bit_cnt  <= bit_cnt - 5'd1;
                        state    <= (bit_cnt == 5'd1) ? DONE : LEAD;
                        if (drive) mosi_q <= next_bit;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                    ss_q  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Shift registers and frame settings
    always_ff @(posedge seq) begin
        if (take) begin
            cpha_q   <= xfer.cpha;
            cpol_q   <= xfer.cpol;
            msb_q    <= xfer.msb_first;
            len_q    <= len_eff;
            shift_tx <= xfer.cpha ? aligned : aligned_next;  // First bit already out for cpha 0
            shift_rx <= '0;
        end else begin
            if (drive) shift_tx <= shift_tx_next;
            if (sample) begin
                shift_rx <= msb_q ? {shift_rx[14:0], miso} : {miso, shift_rx[15:1]};
            end
        end
    end

    // LSB first fills from the top, so move it down
    assign xfer.rx_data  = msb_q ? shift_rx : (shift_rx >> (5'd16 - len_q));
    assign xfer.rx_valid = (state == DONE) & xfer.enable;
    assign xfer.tx_ready = (state == IDLE) & xfer.enable;
    assign xfer.busy     = (state != IDLE);

    assign sclk = sclk_q;
    assign mosi = mosi_q;
    assign ss_n = ss_q;

endmodule

// ==== rtl/spi_periph.sv ====
module spi_periph #(
    parameter int BAUD_WIDTH = 16
) (
    input  logic               seq,
    input  logic               reset,

    // APB slave
    input  spi_pkg::reg_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  spi_pkg::word_t     pwdata,
    output spi_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr,

    output logic               irq,

    // SPI master
    output logic               sclk,
    output logic               mosi,
    input  logic               miso,
    output logic               ss_n
);

    spi_xfer_if #(
        .BAUD_WIDTH (BAUD_WIDTH)
    ) xfer ();

    spi_regs #(
        .BAUD_WIDTH (BAUD_WIDTH)
    ) u_regs (
        .seq     (seq),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .xfer    (xfer.regs)
    );

    spi_engine #(
        .BAUD_WIDTH (BAUD_WIDTH)
    ) u_engine (
        .seq   (seq),
        .reset (reset),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso),
        .ss_n  (ss_n),
        .xfer  (xfer.engine)
    );

endmodule

// ==== test/spi_periph_tb.sv ====
module spi_periph_tb;
    import spi_pkg::*;

    localparam int NUM_FRAMES   = 60;
    localparam int MAX_BRR      = 4;
    localparam int MAX_LEN      = 16;
    localparam int FRAME_CYCLES = 2 * MAX_BRR * MAX_LEN + 2;
    // Each frame with about 12 APB transfers of 3 cycles, plus the register tests
    localparam int CYCLE_LIMIT  = (NUM_FRAMES + 3) * (FRAME_CYCLES + 36) + 300;

    logic       seq;
    logic       reset;
    reg_addr_t  paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       pslverr;
    logic       irq;
    logic       sclk;
    logic       mosi;
    logic       miso;
    logic       ss_n;

    logic       cfg_cpol;    // Frame setup seen by the slave model
    logic       cfg_cpha;
    logic       cfg_msb;
    logic [4:0] cfg_len;
    frame_t     reply_q[$];  // Replies waiting for a frame
    frame_t     reply_log[$];
    frame_t     mosi_log[$];
    int         cycles = 0;

    spi_periph #(.BAUD_WIDTH (16)) u_dut (.*);

    initial begin
        seq = 1'b0;
        forever #10 seq = ~seq;
    end

    always @(posedge seq) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the test did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic frame_t len_mask(input logic [4:0] len);
        logic [16:0] m;
        m = (17'd1 << len) - 17'd1;
        return m[15:0];
    endfunction

    // Bit of the frame that goes out as the i-th bit on the wire
    function automatic logic [3:0] bit_pos(input logic [4:0] i);
        logic [4:0] p;
        p = cfg_msb ? (cfg_len - 5'd1 - i) : i;
        return p[3:0];
    endfunction

    task automatic apb_access(input logic wr, input reg_addr_t addr, input word_t wdata,
                              input logic exp_err, output word_t rdata);
        @(posedge seq);
        psel   <= 1'b1;
        pwrite <= wr;
        paddr  <= addr;
        pwdata <= wdata;
        @(posedge seq);
        penable <= 1'b1;
        @(negedge seq);      // Middle of the access cycle
        rdata = prdata;
        assert (pready) else report_fail("pready low in the access cycle");
        assert (pslverr == exp_err) else
            report_fail($sformatf("pslverr %b at offset %h, expected %b", pslverr, addr, exp_err));
        @(posedge seq);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input reg_addr_t addr, input word_t exp);
        word_t rd;
        apb_access(1'b0, addr, '0, 1'b0, rd);
        assert (rd == exp) else
            report_fail($sformatf("offset %h read %h, expected %h", addr, rd, exp));
    endtask

    // Poll SR until one of the given flags is set
    task automatic wait_status(input word_t flag);
        word_t sr;
        sr = '0;
        while ((sr & flag) == '0) begin
            apb_access(1'b0, SR_OFFS, '0, 1'b0, sr);
        end
    endtask

    task automatic check_irq(input logic exp);
        word_t sr;
        apb_access(1'b0, SR_OFFS, '0, 1'b0, sr);
        @(negedge seq);
        assert (irq == exp) else
            report_fail($sformatf("irq %b, expected %b, SR %h", irq, exp, sr));
    endtask

    task automatic configure(input logic cpol, input logic cpha, input logic msb,
                             input logic [4:0] len, input word_t brr);
        word_t cr;
        word_t rd;
        cfg_cpol = cpol;
        cfg_cpha = cpha;
        cfg_msb  = msb;
        cfg_len  = len;
        cr = '0;
        cr[CR_ENABLE]    = 1'b1;
        cr[CR_MASTER]    = 1'b1;
        cr[CR_CPHA]      = cpha;
        cr[CR_CPOL]      = cpol;
        cr[CR_MSB_FIRST] = msb;
        cr[CR_LEN_MSB:CR_LEN_LSB] = len[3:0];  // 16 wraps to 0
        apb_access(1'b1, BRR_OFFS, brr, 1'b0, rd);
        apb_access(1'b1, CR_OFFS, cr, 1'b0, rd);
    endtask

    task automatic send_word(input frame_t data);
        word_t rnd;
        word_t rd;
        wait_status(32'h1);
        rnd = $urandom;
        reply_q.push_back(rnd[15:0]);
        apb_access(1'b1, DR_OFFS, {16'h0, data}, 1'b0, rd);
    endtask

    task automatic check_capture(input frame_t data);
        frame_t got;
        assert (mosi_log.size() > 0) else report_fail("the SPI slave model saw no frame");
        got = mosi_log.pop_front();
        assert (got == (data & len_mask(cfg_len))) else
            report_fail($sformatf("mosi frame %h, expected %h", got, data & len_mask(cfg_len)));
    endtask

    task automatic check_dr();
        frame_t reply;
        assert (reply_log.size() > 0) else report_fail("no reply was sent on miso");
        reply = reply_log.pop_front();
        check_reg(DR_OFFS, {16'h0, reply & len_mask(cfg_len)});
    endtask

    // SPI slave shifting a reply out on miso while capturing mosi
    initial begin : slave_model
        frame_t     reply;
        frame_t     cap;
        logic [4:0] n_tx;
        logic [4:0] n_rx;
        logic       lead;
        miso = 1'b0;
        forever begin
            @(negedge ss_n);
            assert (reply_q.size() > 0) else report_fail("frame started with no reply queued");
            reply = reply_q.pop_front();
            reply_log.push_back(reply);
            cap  = '0;
            n_tx = '0;
            n_rx = '0;
            if (!cfg_cpha) begin
                miso <= reply[bit_pos(5'd0)];  // Ahead of the first leading edge
                n_tx = 5'd1;
            end
            while (n_rx < cfg_len) begin
                @(sclk);
                lead = (sclk != cfg_cpol);
                if (lead != cfg_cpha) begin     // Sampling edge
                    cap[bit_pos(n_rx)] = mosi;
                    n_rx = n_rx + 5'd1;
                end else if (n_tx < cfg_len) begin
                    miso <= reply[bit_pos(n_tx)];
                    n_tx = n_tx + 5'd1;
                end
            end
            mosi_log.push_back(cap);
        end
    end

    initial begin : main_test
        word_t      rd;
        word_t      rnd;
        word_t      brr;
        frame_t     data;
        logic [4:0] len;
        void'($urandom(32'h18f8));
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge seq);
        reset <= 1'b0;
        @(negedge seq);
        assert (!irq && ss_n && !sclk && !mosi) else
            report_fail($sformatf("after reset irq %b ss_n %b sclk %b mosi %b",
                                  irq, ss_n, sclk, mosi));
        check_reg(SR_OFFS, 32'h1);

        // Unused bits read back as zero
        apb_access(1'b1, BRR_OFFS, 32'hABCD_1234, 1'b0, rd);
        check_reg(BRR_OFFS, 32'h0000_1234);
        apb_access(1'b1, CR_OFFS, 32'hFFFF_FFFE, 1'b0, rd);
        check_reg(CR_OFFS, 32'h0000_0F1E);
        apb_access(1'b1, IER_OFFS, 32'h5, 1'b0, rd);
        check_reg(IER_OFFS, 32'h5);
        apb_access(1'b1, IER_OFFS, 32'h0, 1'b0, rd);
        apb_access(1'b0, 5'h14, '0, 1'b1, rd);
        apb_access(1'b1, 5'h1C, 32'h1, 1'b1, rd);

        apb_access(1'b1, CR_OFFS, 32'h0, 1'b0, rd);  // Disabled
        apb_access(1'b0, DR_OFFS, '0, 1'b1, rd);
        apb_access(1'b1, DR_OFFS, 32'h55, 1'b1, rd);

        for (int i = 0; i < NUM_FRAMES; i++) begin
            rnd = $urandom_range(MAX_LEN, 1);
            len = rnd[4:0];
            brr = $urandom_range(MAX_BRR, 1);
            rnd = $urandom;
            data = rnd[31:16];
            configure(rnd[0], rnd[1], rnd[2], len, brr);
            send_word(data);
            wait_status(32'h2);
            check_capture(data);
            check_dr();
        end

        apb_access(1'b1, IER_OFFS, 32'h0, 1'b0, rd);
        check_irq(1'b0);                 // TBE set but masked
        apb_access(1'b1, IER_OFFS, 32'h1, 1'b0, rd);
        check_irq(1'b1);
        apb_access(1'b1, IER_OFFS, 32'h2, 1'b0, rd);
        check_irq(1'b0);
        send_word(16'h00A5);
        wait_status(32'h2);
        check_irq(1'b1);
        check_capture(16'h00A5);
        check_dr();
        check_irq(1'b0);                 // RBF cleared by the DR read
        apb_access(1'b1, IER_OFFS, 32'h8, 1'b0, rd);
        check_irq(1'b0);

        // A shifts while B waits in the buffer, so the third write bounces
        configure(1'b0, 1'b0, 1'b1, 5'd8, 32'd4);
        send_word(16'h003C);
        send_word(16'h00C3);
        apb_access(1'b1, DR_OFFS, 32'h0000_FF3C, 1'b1, rd);
        check_reg(SR_OFFS, 32'h4);       // Only BUSY while A is on the wire
        wait_status(32'h8);
        check_irq(1'b1);
        check_capture(16'h003C);
        check_capture(16'h00C3);
        data = reply_log.pop_front();    // Lost to the overrun
        check_dr();
        apb_access(1'b1, SR_OFFS, 32'h8, 1'b0, rd);
        check_reg(SR_OFFS, 32'h1);
        check_irq(1'b0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== spi_periph.f ====
rtl/spi_pkg.sv
rtl/spi_xfer_if.sv
rtl/spi_regs.sv
rtl/spi_engine.sv
rtl/spi_periph.sv
test/spi_periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module spi_periph_tb -Mdir obj_dir -f spi_periph.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vspi_periph_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
